// ==== rtl/dp_cfg.svh ====
// Dispatch width, register counts, zero-register index and RV32 opcode/funct/WFI codes
`ifndef DP_CFG_SVH
`define DP_CFG_SVH

// ==============================
// Stage sizing
// ==============================
`define DP_NUM          4
`define PHY_REG_NUM     64
`define ARCH_REG_NUM    32
`define ZERO_REG        0
`define XLEN            32

// ==============================
// RV32 major opcodes
// ==============================
`define OP_LUI          7'b0110111
`define OP_AUIPC        7'b0010111
`define OP_JAL          7'b1101111
`define OP_JALR         7'b1100111
`define OP_BRANCH       7'b1100011
`define OP_LOAD         7'b0000011
`define OP_STORE        7'b0100011
`define OP_IMM          7'b0010011
`define OP_REG          7'b0110011
`define OP_SYSTEM       7'b1110011

// funct3 of the integer ALU group
`define F3_ADD          3'b000
`define F3_SLL          3'b001
`define F3_SLT          3'b010
`define F3_SLTU         3'b011
`define F3_XOR          3'b100
`define F3_SR           3'b101
`define F3_OR           3'b110
`define F3_AND          3'b111

// funct3 of CSR access
`define F3_PRIV         3'b000
`define F3_CSRRW        3'b001
`define F3_CSRRS        3'b010
`define F3_CSRRC        3'b011

// funct7 variants
`define F7_BASE         7'b0000000
`define F7_ALT          7'b0100000
`define F7_MULDIV       7'b0000001

// Full WFI word
`define WFI_INST        32'h10500073

`endif

// ==== rtl/dp_pkg.sv ====
// Dispatch types: instruction, PC, register index, tag, count, unit class, ALU function, packet
`include "dp_cfg.svh"

package dp_pkg;

    // ==============================
    // Scalar types
    // ==============================
    typedef logic [31:0]                        inst_t;
    typedef logic [`XLEN-1:0]                   pc_t;
    typedef logic [$clog2(`ARCH_REG_NUM)-1:0]   arch_reg_t;
    typedef logic [$clog2(`PHY_REG_NUM)-1:0]    tag_t;
    // Holds 0..DP_NUM inclusive
    typedef logic [$clog2(`DP_NUM+1)-1:0]       dp_cnt_t;

    // ==============================
    // Decode enumerations
    // ==============================
    // Target function unit, NONE for no-op and WFI
    typedef enum logic [2:0] {
        FU_ALU,
        FU_MULT,
        FU_LOAD,
        FU_STORE,
        FU_BRANCH,
        FU_JUMP,
        FU_CSR,
        FU_NONE
    } fu_class_e;

    // ALU ops followed by the four multiply flavours
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_MUL,
        ALU_MULH,
        ALU_MULHSU,
        ALU_MULHU
    } alu_func_e;

    // Per-slot packet sent to ROB and RS
    typedef struct packed {
        pc_t        pc;
        fu_class_e  fu_class;
        alu_func_e  alu_func;
        arch_reg_t  rd;
        arch_reg_t  rs1;
        arch_reg_t  rs2;
        tag_t       tag;
        logic       halt;
        logic       illegal;
    } dec_pkt_t;

endpackage

// ==== rtl/inst_decoder.sv ====
// Single-slot RV32IM, CSR and WFI decoder to unit class, ALU function, registers and flags
`include "dp_cfg.svh"

module inst_decoder (
    input  dp_pkg::inst_t       inst_i,
    input  logic                slot_valid_i,
    output dp_pkg::fu_class_e   fu_class_o,
    output dp_pkg::alu_func_e   alu_func_o,
    output dp_pkg::arch_reg_t   rd_o,
    output dp_pkg::arch_reg_t   rs1_o,
    output dp_pkg::arch_reg_t   rs2_o,
    output logic                halt_o,
    output logic                illegal_o
);
    import dp_pkg::*;

    // Instruction fields
    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    // Which register fields the format really uses
    logic           use_rd;
    logic           use_rs1;
    logic           use_rs2;

    assign opcode   = inst_i[6:0];
    assign funct3   = inst_i[14:12];
    assign funct7   = inst_i[31:25];

    // ==============================
    // Opcode decode
    // ==============================
    always_comb begin
        // No-op defaults, also what an empty slot shows
        fu_class_o  = FU_NONE;
        alu_func_o  = ALU_ADD;
        use_rd      = 1'b0;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        halt_o      = 1'b0;
        illegal_o   = 1'b0;
        if (slot_valid_i) begin
            case (opcode)
                `OP_LUI, `OP_AUIPC: begin
                    fu_class_o  = FU_ALU;
                    use_rd      = 1'b1;
                end
                `OP_JAL: begin
                    fu_class_o  = FU_JUMP;
                    use_rd      = 1'b1;
                end
                `OP_JALR: begin
                    if (funct3 == 3'b000) begin
                        fu_class_o  = FU_JUMP;
                        use_rd      = 1'b1;
                        use_rs1     = 1'b1;
                    end else begin
                        illegal_o   = 1'b1;
                    end
                end
                `OP_BRANCH: begin
                    // funct3 010 and 011 are unassigned
                    if (funct3[2:1] != 2'b01) begin
                        fu_class_o  = FU_BRANCH;
                        use_rs1     = 1'b1;
                        use_rs2     = 1'b1;
                    end else begin
                        illegal_o   = 1'b1;
                    end
                end
                `OP_LOAD: begin
                    // LB LH LW LBU LHU only
                    if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
                        fu_class_o  = FU_LOAD;
                        use_rd      = 1'b1;
                        use_rs1     = 1'b1;
                    end else begin
                        illegal_o   = 1'b1;
                    end
                end
                `OP_STORE: begin
                    // SB SH SW only
                    if (!funct3[2] && funct3 != 3'b011) begin
                        fu_class_o  = FU_STORE;
                        use_rs1     = 1'b1;
                        use_rs2     = 1'b1;
                    end else begin
                        illegal_o   = 1'b1;
                    end
                end
                `OP_IMM: begin
                    fu_class_o  = FU_ALU;
                    use_rd      = 1'b1;
                    use_rs1     = 1'b1;
                    case (funct3)
                        `F3_ADD:    alu_func_o = ALU_ADD;
                        `F3_SLT:    alu_func_o = ALU_SLT;
                        `F3_SLTU:   alu_func_o = ALU_SLTU;
                        `F3_XOR:    alu_func_o = ALU_XOR;
                        `F3_OR:     alu_func_o = ALU_OR;
                        `F3_AND:    alu_func_o = ALU_AND;
                        `F3_SLL:    begin
                            alu_func_o  = ALU_SLL;
                            illegal_o   = (funct7 != `F7_BASE);
                        end
                        default:    begin
                            // Shift right, funct7 picks logical or arithmetic
                            alu_func_o  = (funct7 == `F7_ALT) ? ALU_SRA : ALU_SRL;
                            illegal_o   = (funct7 != `F7_BASE) && (funct7 != `F7_ALT);
                        end
                    endcase
                end
                `OP_REG: begin
                    use_rd      = 1'b1;
                    use_rs1     = 1'b1;
                    use_rs2     = 1'b1;
                    if (funct7 == `F7_MULDIV) begin
                        fu_class_o  = FU_MULT;
                        case (funct3)
                            3'b000:     alu_func_o = ALU_MUL;
                            3'b001:     alu_func_o = ALU_MULH;
                            3'b010:     alu_func_o = ALU_MULHSU;
                            3'b011:     alu_func_o = ALU_MULHU;
                            // No divider behind this stage
                            default:    illegal_o  = 1'b1;
                        endcase
                    end else if (funct7 == `F7_BASE) begin
                        fu_class_o  = FU_ALU;
                        case (funct3)
                            `F3_ADD:    alu_func_o = ALU_ADD;
                            `F3_SLL:    alu_func_o = ALU_SLL;
                            `F3_SLT:    alu_func_o = ALU_SLT;
                            `F3_SLTU:   alu_func_o = ALU_SLTU;
                            `F3_XOR:    alu_func_o = ALU_XOR;
                            `F3_SR:     alu_func_o = ALU_SRL;
                            `F3_OR:     alu_func_o = ALU_OR;
                            default:    alu_func_o = ALU_AND;
                        endcase
                    end else if (funct7 == `F7_ALT && funct3 == `F3_ADD) begin
                        fu_class_o  = FU_ALU;
                        alu_func_o  = ALU_SUB;
                    end else if (funct7 == `F7_ALT && funct3 == `F3_SR) begin
                        fu_class_o  = FU_ALU;
                        alu_func_o  = ALU_SRA;
                    end else begin
                        illegal_o   = 1'b1;
                    end
                end
                `OP_SYSTEM: begin
                    case (funct3)
                        `F3_PRIV:   begin
                            // WFI halts, other privileged ops are not handled
                            halt_o      = (inst_i == `WFI_INST);
                            illegal_o   = (inst_i != `WFI_INST);
                        end
                        `F3_CSRRW, `F3_CSRRS, `F3_CSRRC: begin
                            fu_class_o  = FU_CSR;
                            use_rd      = 1'b1;
                            use_rs1     = 1'b1;
                        end
                        default:    illegal_o = 1'b1;
                    endcase
                end
                default: begin
                    illegal_o   = 1'b1;
                end
            endcase
        end
    end

    // Unused fields read as x0
    assign rd_o     = use_rd  ? inst_i[11:7]  : arch_reg_t'(`ZERO_REG);
    assign rs1_o    = use_rs1 ? inst_i[19:15] : arch_reg_t'(`ZERO_REG);
    assign rs2_o    = use_rs2 ? inst_i[24:20] : arch_reg_t'(`ZERO_REG);

endmodule

// ==== rtl/dp_hazard_count.sv ====
// Structural hazard check giving raw window, dispatch count and free-list consumption count
`include "dp_cfg.svh"

module dp_hazard_count (
    input  dp_pkg::dp_cnt_t                     fiq_avail_i,
    input  dp_pkg::dp_cnt_t                     rob_avail_i,
    input  dp_pkg::dp_cnt_t                     fl_avail_i,
    input  dp_pkg::dp_cnt_t                     rs_avail_i,
    input  logic [`DP_NUM-1:0]                  illegal_i,
    input  dp_pkg::arch_reg_t [`DP_NUM-1:0]     rd_i,
    output dp_pkg::dp_cnt_t                     raw_num_o,
    output dp_pkg::dp_cnt_t                     dp_num_o,
    output dp_pkg::dp_cnt_t                     fl_num_o
);
    import dp_pkg::*;

    localparam dp_cnt_t DP_MAX = dp_cnt_t'(`DP_NUM);

    // Pairwise minimum tree
    dp_cnt_t    min_fiq_rob;
    dp_cnt_t    min_fl_rs;
    dp_cnt_t    min_all;

    // ==============================
    // Raw window from credits
    // ==============================
    always_comb begin
        min_fiq_rob = (fiq_avail_i < rob_avail_i) ? fiq_avail_i : rob_avail_i;
        min_fl_rs   = (fl_avail_i < rs_avail_i) ? fl_avail_i : rs_avail_i;
        min_all     = (min_fiq_rob < min_fl_rs) ? min_fiq_rob : min_fl_rs;
        // Never more than the slot count
        raw_num_o   = (min_all > DP_MAX) ? DP_MAX : min_all;
    end

    // Cut at the first illegal slot, scanning down so the oldest one wins
    always_comb begin
        dp_num_o = raw_num_o;
        for (int i = `DP_NUM - 1; i >= 0; i--) begin
            if ((dp_cnt_t'(i) < raw_num_o) && illegal_i[i]) begin
                dp_num_o = dp_cnt_t'(i);
            end
        end
    end

    // Tags only consumed by dispatched writers of a real rd
    always_comb begin
        fl_num_o = '0;
        for (int i = 0; i < `DP_NUM; i++) begin
            if ((dp_cnt_t'(i) < dp_num_o) && (rd_i[i] != arch_reg_t'(`ZERO_REG))) begin
                fl_num_o = fl_num_o + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/fl_tag_router.sv ====
// Prefix-count routing of free-list head tags to slots that write a nonzero rd
`include "dp_cfg.svh"

module fl_tag_router (
    input  dp_pkg::dp_cnt_t                     raw_num_i,
    input  dp_pkg::arch_reg_t [`DP_NUM-1:0]     rd_i,
    input  dp_pkg::tag_t [`DP_NUM-1:0]          fl_tag_i,
    output dp_pkg::tag_t [`DP_NUM-1:0]          tag_o
);
    import dp_pkg::*;

    // Width of a free-list head position
    localparam int IDX_W = $clog2(`DP_NUM);

    // ==============================
    // Tag routing
    // ==============================
    always_comb begin : route
        // Running count of earlier tag consumers
        dp_cnt_t fl_idx;
        fl_idx = '0;
        for (int i = 0; i < `DP_NUM; i++) begin
            tag_o[i] = tag_t'(`ZERO_REG);
            if ((dp_cnt_t'(i) < raw_num_i) && (rd_i[i] != arch_reg_t'(`ZERO_REG))) begin
                // fl_idx never passes i here, so the low bits suffice
                tag_o[i] = fl_tag_i[fl_idx[IDX_W-1:0]];
                fl_idx   = fl_idx + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/dp_latch.sv ====
// Pipeline register for dispatch counts and per-slot decoded packets
`include "dp_cfg.svh"

module dp_latch (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  dp_pkg::dp_cnt_t                     dp_num_i,
    input  dp_pkg::dp_cnt_t                     fl_num_i,
    input  dp_pkg::dec_pkt_t [`DP_NUM-1:0]      pkt_i,
    output dp_pkg::dp_cnt_t                     dp_num_o,
    output dp_pkg::dp_cnt_t                     fl_num_o,
    output dp_pkg::dec_pkt_t [`DP_NUM-1:0]      pkt_o
);

    // ==============================
    // Counts
    // ==============================
    // Zero counts after reset, nothing dispatched
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dp_num_o <= '0;
            fl_num_o <= '0;
        end else begin
            dp_num_o <= dp_num_i;
            fl_num_o <= fl_num_i;
        end
    end

    // ==============================
    // Packets
    // ==============================
    // Loads every cycle, stalls show up as a zero count
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pkt_o <= '0;
        end else begin
            pkt_o <= pkt_i;
        end
    end

endmodule

// ==== rtl/dp_top.sv ====
// Dispatch stage top: slot decoders, hazard counter, free-list tag router and output latch
`include "dp_cfg.svh"

module dp_top (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    // Fetch queue, slot 0 oldest
    input  dp_pkg::dp_cnt_t                     fiq_avail_i,
    input  dp_pkg::inst_t [`DP_NUM-1:0]         fiq_inst_i,
    input  dp_pkg::pc_t [`DP_NUM-1:0]           fiq_pc_i,
    // Back-end credits
    input  dp_pkg::dp_cnt_t                     rob_avail_i,
    input  dp_pkg::dp_cnt_t                     fl_avail_i,
    input  dp_pkg::dp_cnt_t                     rs_avail_i,
    input  dp_pkg::tag_t [`DP_NUM-1:0]          fl_tag_i,
    // Registered results
    output dp_pkg::dp_cnt_t                     dp_num_o,
    output dp_pkg::dp_cnt_t                     fl_num_o,
    output dp_pkg::dec_pkt_t [`DP_NUM-1:0]      pkt_o
);
    import dp_pkg::*;

    // Decoder outputs per slot
    logic       [`DP_NUM-1:0]   slot_valid;
    fu_class_e  [`DP_NUM-1:0]   fu_class;
    alu_func_e  [`DP_NUM-1:0]   alu_func;
    arch_reg_t  [`DP_NUM-1:0]   rd;
    arch_reg_t  [`DP_NUM-1:0]   rs1;
    arch_reg_t  [`DP_NUM-1:0]   rs2;
    logic       [`DP_NUM-1:0]   halt;
    logic       [`DP_NUM-1:0]   illegal;
    // Counts and routed tags
    dp_cnt_t                    raw_num;
    dp_cnt_t                    dp_num;
    dp_cnt_t                    fl_num;
    tag_t       [`DP_NUM-1:0]   tag;
    dec_pkt_t   [`DP_NUM-1:0]   pkt;

    // ==============================
    // Per-slot decode and packing
    // ==============================
    for (genvar s = 0; s < `DP_NUM; s++) begin : gen_slot
        // Raw window depends on credits only, no loop through illegal
        assign slot_valid[s] = (dp_cnt_t'(s) < raw_num);

        inst_decoder decoder_inst (
            .inst_i         (fiq_inst_i[s]),
            .slot_valid_i   (slot_valid[s]),
            .fu_class_o     (fu_class[s]),
            .alu_func_o     (alu_func[s]),
            .rd_o           (rd[s]),
            .rs1_o          (rs1[s]),
            .rs2_o          (rs2[s]),
            .halt_o         (halt[s]),
            .illegal_o      (illegal[s])
        );

        assign pkt[s] = '{
            pc:       fiq_pc_i[s],
            fu_class: fu_class[s],
            alu_func: alu_func[s],
            rd:       rd[s],
            rs1:      rs1[s],
            rs2:      rs2[s],
            tag:      tag[s],
            halt:     halt[s],
            illegal:  illegal[s]
        };
    end

    // ==============================
    // Counts, tags, latch
    // ==============================
    dp_hazard_count hazard_count_inst (
        .fiq_avail_i    (fiq_avail_i),
        .rob_avail_i    (rob_avail_i),
        .fl_avail_i     (fl_avail_i),
        .rs_avail_i     (rs_avail_i),
        .illegal_i      (illegal),
        .rd_i           (rd),
        .raw_num_o      (raw_num),
        .dp_num_o       (dp_num),
        .fl_num_o       (fl_num)
    );

    fl_tag_router tag_router_inst (
        .raw_num_i      (raw_num),
        .rd_i           (rd),
        .fl_tag_i       (fl_tag_i),
        .tag_o          (tag)
    );

    dp_latch latch_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .dp_num_i       (dp_num),
        .fl_num_i       (fl_num),
        .pkt_i          (pkt),
        .dp_num_o       (dp_num_o),
        .fl_num_o       (fl_num_o),
        .pkt_o          (pkt_o)
    );

endmodule

// ==== testbench/tb_dp_top.sv ====
// Dispatch stage testbench with vector file stimulus, clock, reset, compare tasks and timeout
`include "dp_cfg.svh"

module tb_dp_top;
    import dp_pkg::*;

    // ==============================
    // Vector file layout
    // ==============================
    localparam int NUM_VEC      = 24;
    localparam int VEC_WORDS    = 12;
    localparam int MAX_CYCLES   = NUM_VEC + 20;
    // Word offsets inside one vector
    localparam int W_AVAIL      = 0;
    localparam int W_INST       = 1;
    localparam int W_PC         = 5;
    localparam int W_TAG        = 6;
    localparam int W_CNT        = 7;
    localparam int W_PKT        = 8;

    logic [39:0]                vec_mem [0:NUM_VEC*VEC_WORDS-1];
    int                         cycle_cnt = 0;

    // DUT signals
    logic                       clk;
    logic                       rst_n;
    dp_cnt_t                    fiq_avail;
    inst_t      [`DP_NUM-1:0]   fiq_inst;
    pc_t        [`DP_NUM-1:0]   fiq_pc;
    dp_cnt_t                    rob_avail;
    dp_cnt_t                    fl_avail;
    dp_cnt_t                    rs_avail;
    tag_t       [`DP_NUM-1:0]   fl_tag;
    dp_cnt_t                    dp_num;
    dp_cnt_t                    fl_num;
    dec_pkt_t   [`DP_NUM-1:0]   pkt;

    dp_top dut0 (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .fiq_avail_i    (fiq_avail),
        .fiq_inst_i     (fiq_inst),
        .fiq_pc_i       (fiq_pc),
        .rob_avail_i    (rob_avail),
        .fl_avail_i     (fl_avail),
        .rs_avail_i     (rs_avail),
        .fl_tag_i       (fl_tag),
        .dp_num_o       (dp_num),
        .fl_num_o       (fl_num),
        .pkt_o          (pkt)
    );

    // Period 4
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==============================
    // Vector field access
    // ==============================
    // Slot PC from the 16-bit base of the line
    function automatic pc_t vec_pc(int v, int s);
        return pc_t'(vec_mem[v*VEC_WORDS + W_PC][15:0]) + pc_t'(4 * s);
    endfunction

    // Tag of slot 0 sits in the top byte
    function automatic tag_t vec_tag(int v, int s);
        return tag_t'(vec_mem[v*VEC_WORDS + W_TAG] >> (8 * (3 - s)));
    endfunction

    // Expected packet word: class, alu, rd, rs1, rs2, {halt, illegal, tag}
    function automatic dec_pkt_t expect_pkt(logic [39:0] w, pc_t pc);
        dec_pkt_t p;
        p.pc        = pc;
        p.fu_class  = fu_class_e'(w[38:36]);
        p.alu_func  = alu_func_e'(w[35:32]);
        p.rd        = w[28:24];
        p.rs1       = w[20:16];
        p.rs2       = w[12:8];
        p.halt      = w[7];
        p.illegal   = w[6];
        p.tag       = w[5:0];
        return p;
    endfunction

    // ==============================
    // Compare tasks
    // ==============================
    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_cnt(string what, dp_cnt_t got, dp_cnt_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %0t: %s got %0d expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_pkt(int v, int s, dec_pkt_t got, dec_pkt_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %0t: vector %0d slot %0d packet got %h expected %h",
                                $time, v, s, got, exp));
        end
    endtask

    // Illegal flag of the slot that stopped dispatch
    task automatic check_flag(int v, int s, logic got, logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %0t: vector %0d slot %0d illegal got %b expected %b",
                                $time, v, s, got, exp));
        end
    endtask

    // ==============================
    // Drive and check one vector
    // ==============================
    task automatic apply_vector(int v);
        logic [39:0] av;
        av = vec_mem[v*VEC_WORDS + W_AVAIL];
        fiq_avail <= dp_cnt_t'(av[15:12]);
        rob_avail <= dp_cnt_t'(av[11:8]);
        fl_avail  <= dp_cnt_t'(av[7:4]);
        rs_avail  <= dp_cnt_t'(av[3:0]);
        for (int s = 0; s < `DP_NUM; s++) begin
            fiq_inst[s] <= vec_mem[v*VEC_WORDS + W_INST + s][31:0];
            fiq_pc[s]   <= vec_pc(v, s);
            fl_tag[s]   <= vec_tag(v, s);
        end
    endtask

    task automatic check_vector(int v);
        dp_cnt_t    exp_dp;
        dp_cnt_t    exp_fl;
        dec_pkt_t   exp_p;
        exp_dp = dp_cnt_t'(vec_mem[v*VEC_WORDS + W_CNT][7:4]);
        exp_fl = dp_cnt_t'(vec_mem[v*VEC_WORDS + W_CNT][3:0]);
        check_cnt($sformatf("vector %0d dp_num", v), dp_num, exp_dp);
        check_cnt($sformatf("vector %0d fl_num", v), fl_num, exp_fl);
        for (int s = 0; s < `DP_NUM; s++) begin
            exp_p = expect_pkt(vec_mem[v*VEC_WORDS + W_PKT + s], vec_pc(v, s));
            if (dp_cnt_t'(s) < exp_dp) begin
                check_pkt(v, s, pkt[s], exp_p);
            end else if (dp_cnt_t'(s) == exp_dp && exp_p.illegal) begin
                check_flag(v, s, pkt[s].illegal, 1'b1);
            end
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        rst_n     = 1'b0;
        fiq_avail = '0;
        fiq_inst  = '0;
        fiq_pc    = '0;
        rob_avail = '0;
        fl_avail  = '0;
        rs_avail  = '0;
        fl_tag    = '0;
        $readmemh("testbench/dp_vectors.txt", vec_mem);
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        // Latch still cleared before any vector
        @(negedge clk);
        check_cnt("dp_num after reset", dp_num, '0);
        check_cnt("fl_num after reset", fl_num, '0);
        // Drive vector v while vector v-1 shows on the outputs
        for (int v = 0; v <= NUM_VEC; v++) begin
            @(posedge clk);
            if (v < NUM_VEC) begin
                apply_vector(v);
            end
            @(negedge clk);
            if (v > 0) begin
                check_vector(v - 1);
            end
        end
        $display("** PASS **");
        $finish;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            abort_run($sformatf("Timeout: run did not end within %0d cycles", MAX_CYCLES));
        end
    end

endmodule

// ==== testbench/dp_vectors.txt ====
// avail(fiq rob fl rs) inst0 inst1 inst2 inst3 pc_base tags(slot0..3) counts(dp fl) pkt0..pkt3
// pkt: class alu rd rs1 rs2 {halt,illegal,tag}, slot pc = pc_base + 4*slot
// Slots at or past dp are not compared, except the illegal flag of the slot at dp
// Legal groups, each credit in turn the limit
4444 00510093 002081B3 40118233 0FF24293 1000 21222324 44 0001020021 0003010222 0104030123 0605040024
2444 02208333 0241B3B3 00812403 00312623 1010 05060708 22 1a06010205 1d07030406 0000000000 0000000000
4344 00812403 00312623 00208463 010000EF 1020 10111213 31 2008020010 3000020300 4000010200 0000000000
4414 010000EF 00008067 300294F3 10500073 1030 3f3e3d3c 11 500100003f 0000000000 0000000000 0000000000
4443 010000EF 00008067 300294F3 10500073 1040 01020304 32 5001000001 5000010000 6009050002 0000000000
4444 12345537 00000013 341028F3 10500073 1050 0a0b0c0d 42 000a00000a 0000000000 601100000b 7000000080
// Stalls from a zero credit
0444 00510093 002081B3 40118233 0FF24293 1060 21222324 00 0000000000 0000000000 0000000000 0000000000
4044 00510093 002081B3 40118233 0FF24293 1070 21222324 00 0000000000 0000000000 0000000000 0000000000
// Dispatch cut at the first illegal slot
4444 40325593 0062B633 00000000 00209693 1080 30313233 22 090b040030 030c050631 7000000040 0000000000
4444 00000000 00510093 002081B3 40118233 1090 01020304 00 7000000040 0000000000 0000000000 0000000000
4444 00209693 0020E7B3 0001C803 0220C733 10a0 04050607 33 070d010004 050f010205 2010030006 7000000040
4344 00001917 00000073 00510093 002081B3 10b0 11121314 11 0012000011 7000000040 0000000000 0000000000
2444 00510093 002081B3 00000000 00000000 10c0 21222324 22 0001020021 0003010222 0000000000 0000000000
// Zero-rd slots and tag order
4444 00312623 00208033 002081B3 00208463 10d0 2a2b2c2d 41 3000020300 0000010200 000301022a 4000010200
4444 00639123 023119B3 00526663 02208333 10e0 01020304 42 3000070600 1b13020301 4000040500 1a06010202
4424 00312623 00510093 00208463 002081B3 10f0 08090a0b 21 3000020300 0001020008 0000000000 0000000000
4441 300294F3 00510093 002081B3 40118233 1100 15161718 11 6009050015 0000000000 0000000000 0000000000
0000 00510093 002081B3 40118233 0FF24293 1110 21222324 00 0000000000 0000000000 0000000000 0000000000
// Back-to-back mixed groups
4444 0FF24293 40325593 0062B633 00209693 1120 1c1d1e1f 44 060504001c 090b04001d 030c05061e 070d01001f
3334 10500073 0241B3B3 00812403 0020E7B3 1130 20212223 32 7000000080 1d07030420 2008020021 0000000000
4444 0001C803 341028F3 00001917 023119B3 1140 33343536 44 2010030033 6011000034 0012000035 1b13020336
1111 00000013 00510093 002081B3 40118233 1150 01020304 10 0000000000 0000000000 0000000000 0000000000
4444 10500073 10500073 12345537 00000073 1160 3a3b3c3d 31 7000000080 7000000080 000a00003a 7000000040
4444 00510093 002081B3 40118233 0FF24293 1170 01020304 44 0001020001 0003010202 0104030103 0605040004

// ==== project.f ====
+incdir+rtl
rtl/dp_pkg.sv
rtl/inst_decoder.sv
rtl/dp_hazard_count.sv
rtl/fl_tag_router.sv
rtl/dp_latch.sv
rtl/dp_top.sv
testbench/tb_dp_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the dispatch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f project.f --top-module tb_dp_top -o sim_dp_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_dp_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
